// File: dv/fetch_predictor_tb.sv
`include "bp_params.svh"

`default_nettype none

module fetch_predictor_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic        clk;
	logic        gen_rst;
	logic        test_rst;
	logic        rst;
	logic        i_stall;
	logic [1:0]  i_ex_kind;
	logic        i_ex_taken;
	logic [31:0] i_ex_target;
	logic [31:0] o_fetch_pc;
	logic [31:0] o_ex_pc;
	logic        o_ex_vld;
	logic        o_mispred;

	// Test records
	logic [8*16-1:0] t_name [8];
	logic [31:0]     t_stop [8];
	int              t_budget [8];
	int              t_stall_cyc [8];
	int              t_stall_len [8];
	int              t_mispred [8];
	int              t_first [8];
	int              t_rows [8];
	int              n_tests;

	// Program table rows
	logic [31:0] r_pc [32];
	logic [1:0]  r_kind [32];
	logic [31:0] r_target [32];
	int          r_taken [32];
	int          visits [32];
	int          n_rows;

	int errors;
	int failed_tests;
	int total_cycles;
	int cycle_limit;

	assign rst = gen_rst | test_rst;

	tb_clock_gen u_clk (
		.o_clk (clk),
		.o_rst (gen_rst)
	);

	fetch_predictor_top dut (
		.clk         (clk),
		.rst         (rst),
		.i_stall     (i_stall),
		.i_ex_kind   (i_ex_kind),
		.i_ex_taken  (i_ex_taken),
		.i_ex_target (i_ex_target),
		.o_fetch_pc  (o_fetch_pc),
		.o_ex_pc     (o_ex_pc),
		.o_ex_vld    (o_ex_vld),
		.o_mispred   (o_mispred)
	);

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic int find_row(input logic [31:0] pc, input int t);
		int idx;
		idx = -1;
		for (int i = t_first[t]; i < t_first[t] + t_rows[t]; i++) begin
			if (r_pc[i] == pc) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic read_program();
		int fd;
		int n;
		string line;
		logic [8*8-1:0] tok;
		fd = $fopen("dv/program_input.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/program_input.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				tok = '0;
				n = $sscanf(line, "%s", tok);
				if (tok == 64'("test")) begin
					n = $sscanf(line, "%s %s %h %d %d %d %d", tok, t_name[n_tests],
						t_stop[n_tests], t_budget[n_tests], t_stall_cyc[n_tests],
						t_stall_len[n_tests], t_mispred[n_tests]);
					if (n != 7) begin
						$display("test record with missing fields: %0s", line);
						errors++;
					end
					t_first[n_tests] = n_rows;
					t_rows[n_tests] = 0;
					n_tests++;
				end else if (tok == 64'("row")) begin
					n = $sscanf(line, "%s %h %h %h %d", tok, r_pc[n_rows], r_kind[n_rows],
						r_target[n_rows], r_taken[n_rows]);
					if (n != 5) begin
						$display("program row with missing fields: %0s", line);
						errors++;
					end
					t_rows[n_tests-1]++;
					n_rows++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1 test_rst = 1'b1;
		i_stall = 1'b0;
		i_ex_kind = `BP_KIND_NONE;
		repeat (2) @(posedge clk);
		#1 test_rst = 1'b0;
	endtask

	task automatic run_test(input int t);
		int cycle;
		int n_insn;
		int mis;
		int r;
		int start_err;
		logic done;
		logic pend;
		logic [31:0] pend_pc;
		logic [31:0] exp_pc;
		logic [31:0] next_pc;
		cycle = 0;
		n_insn = 0;
		mis = 0;
		done = 1'b0;
		pend = 1'b0;
		pend_pc = '0;
		exp_pc = `BP_RESET_PC;
		start_err = errors;
		for (int i = 0; i < 32; i++) begin
			visits[i] = 0;
		end
		apply_reset();
		while (!done && cycle < t_budget[t]) begin
			@(posedge clk);
			#1;
			cycle++;
			r = find_row(o_ex_pc, t);
			if (r >= 0) begin
				i_ex_kind = r_kind[r];
				i_ex_taken = (r_kind[r] == `BP_KIND_JUMP) || (visits[r] < r_taken[r]);
				i_ex_target = r_target[r];
			end else begin
				i_ex_kind = `BP_KIND_NONE;
				i_ex_taken = 1'b0;
				i_ex_target = '0;
			end
			i_stall = (cycle >= t_stall_cyc[t]) && (cycle < t_stall_cyc[t] + t_stall_len[t]);
			// Redirect must show up one cycle after the pulse
			if (pend) begin
				check_value("o_fetch_pc", o_fetch_pc, pend_pc);
				pend = 1'b0;
			end
			#2;
			next_pc = i_ex_taken ? i_ex_target : o_ex_pc + 32'(`BP_INSN_BYTES);
			if (o_ex_vld) begin
				check_value("o_ex_pc", o_ex_pc, exp_pc);
				if (o_ex_pc == t_stop[t]) begin
					done = 1'b1;
				end else begin
					if (r >= 0) begin
						visits[r]++;
					end
					exp_pc = next_pc;
					n_insn++;
				end
			end
			if (o_mispred) begin
				mis++;
				pend = 1'b1;
				pend_pc = next_pc;
			end
		end
		i_stall = 1'b0;
		if (!done) begin
			$display("%0s did not reach its stop PC within %0d cycles", t_name[t],
				t_budget[t]);
			errors++;
		end else begin
			check_value("mispredicts", mis, t_mispred[t]);
			// Two cycles to fill, one per instruction, two lost per redirect
			check_value("cycles", cycle, 2 + n_insn + 2 * mis + t_stall_len[t]);
		end
		if (errors != start_err) begin
			failed_tests++;
		end
		$display("%0s: %0s, %0d cycles, %0d mispredicts", t_name[t],
			(errors == start_err) ? "ok" : "FAILED", cycle, mis);
	endtask

	always @(posedge clk) begin
		total_cycles++;
		if (cycle_limit > 0 && total_cycles > cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", total_cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int start_err;
		test_rst = 1'b0;
		i_stall = 1'b0;
		i_ex_kind = `BP_KIND_NONE;
		i_ex_taken = 1'b0;
		i_ex_target = '0;
		errors = 0;
		failed_tests = 0;
		total_cycles = 0;
		cycle_limit = 0;
		n_tests = 0;
		n_rows = 0;
		read_program();
		cycle_limit = 16;
		for (int t = 0; t < n_tests; t++) begin
			cycle_limit += t_budget[t] + 6;
		end
		wait (!gen_rst);

		start_err = errors;
		apply_reset();
		check_value("o_fetch_pc", o_fetch_pc, `BP_RESET_PC);
		check_value("o_ex_vld", 32'(o_ex_vld), 32'd0);
		check_value("o_mispred", 32'(o_mispred), 32'd0);
		if (errors != start_err) begin
			failed_tests++;
		end
		$display("reset: %0s", (errors == start_err) ? "ok" : "FAILED");

		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("tests %0d, failed %0d, errors %0d", n_tests + 1, failed_tests, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/program_input.txt
# test: name stop_pc(hex) budget stall_cycle stall_length mispredicts
# row:  pc(hex) kind(1 branch, 2 jump) target(hex) taken_visits
test straight 20 40 0 0 0
test loop 14 60 0 0 2
row c 1 4 3
test jump 10 60 0 0 3
row 4 2 c 0
row c 1 0 2
test stall 20 40 4 3 0

// File: dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// Power-on reset for two cycles
	initial begin
		o_rst = 1'b1;
		repeat (2) @(posedge o_clk);
		#1 o_rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/bp_pkg.sv
src/branch_target_buffer.sv
src/branch_history_table.sv
src/next_pc_select.sv
src/fetch_tag_pipe.sv
src/mispredict_check.sv
src/fetch_predictor_top.sv
dv/tb_clock_gen.sv
dv/fetch_predictor_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module fetch_predictor_tb \
	--Mdir obj_dir -o sim

out=$(./obj_dir/sim)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: src/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

`default_nettype none

// Address width
`define BP_PC_W 32

// Both prediction tables share the same geometry
`define BP_TABLE_ENTRIES 16
`define BP_IDX_W 4
// Byte offset below the index, index in PC[5:2]
`define BP_OFFSET_W 2
`define BP_TAG_W (`BP_PC_W - `BP_IDX_W - `BP_OFFSET_W)

`define BP_RESET_PC 32'h0000_0000
`define BP_INSN_BYTES 4

// Kind of the resolved instruction in EX
`define BP_KIND_NONE 2'd0
`define BP_KIND_BRANCH 2'd1
`define BP_KIND_JUMP 2'd2

`default_nettype wire

`endif

// File: src/bp_pkg.sv
`include "bp_params.svh"

`default_nettype none

package bp_pkg;

	// Any fetch or target address
	typedef logic [`BP_PC_W-1:0] pc_t;

	// Entry select into the BTB and the BHT
	typedef logic [`BP_IDX_W-1:0] btb_idx_t;

	// PC bits above the index
	typedef logic [`BP_TAG_W-1:0] btb_tag_t;

	// Resolved instruction kind, see BP_KIND_* codes
	typedef logic [1:0] ctrl_kind_t;

	// Two-bit saturating direction counter
	// Upper bit set means predict taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} ctr_state_e;

endpackage

`default_nettype wire

// File: src/branch_history_table.sv
`include "bp_params.svh"

`default_nettype none

module branch_history_table (
	input  wire logic        clk,
	input  wire logic        rst,

	input  wire bp_pkg::pc_t i_lookup_pc,
	output logic             o_predict_taken,

	input  wire logic        i_upd_en,
	input  wire bp_pkg::pc_t i_upd_pc,
	input  wire logic        i_actual_taken
);

	bp_pkg::ctr_state_e ctr_q [`BP_TABLE_ENTRIES];

	bp_pkg::btb_idx_t   lookup_idx;
	bp_pkg::btb_idx_t   upd_idx;
	bp_pkg::ctr_state_e ctr_next;

	assign lookup_idx = i_lookup_pc[`BP_OFFSET_W +: `BP_IDX_W];
	assign upd_idx    = i_upd_pc[`BP_OFFSET_W +: `BP_IDX_W];

	// Taken for WEAK_T and STRONG_T
	assign o_predict_taken = (ctr_q[lookup_idx] == bp_pkg::WEAK_T) ||
		(ctr_q[lookup_idx] == bp_pkg::STRONG_T);

	// One step toward the outcome, saturating at both ends
	always_comb begin
		case (ctr_q[upd_idx])
			bp_pkg::STRONG_NT: ctr_next = i_actual_taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
			bp_pkg::WEAK_NT:   ctr_next = i_actual_taken ? bp_pkg::WEAK_T : bp_pkg::STRONG_NT;
			bp_pkg::WEAK_T:    ctr_next = i_actual_taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
			default:           ctr_next = i_actual_taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `BP_TABLE_ENTRIES; i++) begin
				ctr_q[i] <= bp_pkg::WEAK_NT;
			end
		end else if (i_upd_en) begin
			ctr_q[upd_idx] <= ctr_next;
		end
	end

endmodule

`default_nettype wire

// File: src/branch_target_buffer.sv
`include "bp_params.svh"

`default_nettype none

module branch_target_buffer (
	input  wire logic        clk,
	input  wire logic        rst,

	// Fetch side lookup
	input  wire bp_pkg::pc_t i_lookup_pc,
	output bp_pkg::pc_t      o_target,
	output logic             o_hit,

	// Training from EX
	input  wire logic        i_upd_en,
	input  wire bp_pkg::pc_t i_upd_pc,
	input  wire bp_pkg::pc_t i_upd_target
);

	bp_pkg::btb_tag_t tag_mem [`BP_TABLE_ENTRIES];
	bp_pkg::pc_t      target_mem [`BP_TABLE_ENTRIES];
	logic [`BP_TABLE_ENTRIES-1:0] valid_q;

	bp_pkg::btb_idx_t lookup_idx;
	bp_pkg::btb_tag_t lookup_tag;
	bp_pkg::btb_idx_t upd_idx;
	bp_pkg::btb_tag_t upd_tag;

	// Index sits just above the byte offset, tag takes the rest
	assign lookup_idx = i_lookup_pc[`BP_OFFSET_W +: `BP_IDX_W];
	assign lookup_tag = i_lookup_pc[`BP_PC_W-1 -: `BP_TAG_W];
	assign upd_idx    = i_upd_pc[`BP_OFFSET_W +: `BP_IDX_W];
	assign upd_tag    = i_upd_pc[`BP_PC_W-1 -: `BP_TAG_W];

	assign o_hit    = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
	assign o_target = target_mem[lookup_idx];

	// Valid bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else if (i_upd_en) begin
			valid_q[upd_idx] <= 1'b1;
		end
	end

	// Tag and target storage, whole entry is overwritten
	always_ff @(posedge clk) begin
		if (i_upd_en) begin
			tag_mem[upd_idx]    <= upd_tag;
			target_mem[upd_idx] <= i_upd_target;
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_predictor_top.sv
`default_nettype none

module fetch_predictor_top (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               i_stall,

	// Resolved outcome for the instruction on o_ex_pc
	input  wire bp_pkg::ctrl_kind_t i_ex_kind,
	input  wire logic               i_ex_taken,
	input  wire bp_pkg::pc_t        i_ex_target,

	output bp_pkg::pc_t             o_fetch_pc,
	output bp_pkg::pc_t             o_ex_pc,
	output logic                    o_ex_vld,
	output logic                    o_mispred
);

	// Prediction
	logic        btb_hit;
	bp_pkg::pc_t btb_target;
	logic        bht_taken;
	bp_pkg::pc_t pred_next_pc;

	// EX tags
	bp_pkg::pc_t ex_pred_next_pc;

	// Resolution
	logic        mispred;
	bp_pkg::pc_t redirect_pc;
	logic        upd_en;
	bp_pkg::pc_t upd_pc;
	logic        upd_taken;
	bp_pkg::pc_t upd_target;

	branch_target_buffer u_btb (
		.clk          (clk),
		.rst          (rst),
		.i_lookup_pc  (o_fetch_pc),
		.o_target     (btb_target),
		.o_hit        (btb_hit),
		.i_upd_en     (upd_en),
		.i_upd_pc     (upd_pc),
		.i_upd_target (upd_target)
	);

	branch_history_table u_bht (
		.clk             (clk),
		.rst             (rst),
		.i_lookup_pc     (o_fetch_pc),
		.o_predict_taken (bht_taken),
		.i_upd_en        (upd_en),
		.i_upd_pc        (upd_pc),
		.i_actual_taken  (upd_taken)
	);

	next_pc_select u_next_pc (
		.clk            (clk),
		.rst            (rst),
		.i_stall        (i_stall),
		.i_btb_hit      (btb_hit),
		.i_btb_target   (btb_target),
		.i_bht_taken    (bht_taken),
		.i_redirect     (mispred),
		.i_redirect_pc  (redirect_pc),
		.o_fetch_pc     (o_fetch_pc),
		.o_pred_next_pc (pred_next_pc)
	);

	// Misprediction flushes ID and EX
	fetch_tag_pipe u_tag_pipe (
		.clk               (clk),
		.rst               (rst),
		.i_stall           (i_stall),
		.i_flush           (mispred),
		.i_fetch_pc        (o_fetch_pc),
		.i_pred_next_pc    (pred_next_pc),
		.o_ex_pc           (o_ex_pc),
		.o_ex_pred_next_pc (ex_pred_next_pc),
		.o_ex_vld          (o_ex_vld)
	);

	mispredict_check u_resolve (
		.i_ex_vld          (o_ex_vld),
		.i_ex_pc           (o_ex_pc),
		.i_ex_pred_next_pc (ex_pred_next_pc),
		.i_ex_kind         (i_ex_kind),
		.i_ex_taken        (i_ex_taken),
		.i_ex_target       (i_ex_target),
		.o_mispred         (mispred),
		.o_redirect_pc     (redirect_pc),
		.o_upd_en          (upd_en),
		.o_upd_pc          (upd_pc),
		.o_upd_taken       (upd_taken),
		.o_upd_target      (upd_target)
	);

	assign o_mispred = mispred;

endmodule

`default_nettype wire

// File: src/fetch_tag_pipe.sv
`default_nettype none

module fetch_tag_pipe (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        i_stall,
	input  wire logic        i_flush,

	// From fetch
	input  wire bp_pkg::pc_t i_fetch_pc,
	input  wire bp_pkg::pc_t i_pred_next_pc,

	// EX stage view
	output bp_pkg::pc_t      o_ex_pc,
	output bp_pkg::pc_t      o_ex_pred_next_pc,
	output logic             o_ex_vld
);

	// ID stage
	bp_pkg::pc_t id_pc_q;
	bp_pkg::pc_t id_pred_q;
	logic        id_vld_q;

	// EX stage
	bp_pkg::pc_t ex_pc_q;
	bp_pkg::pc_t ex_pred_q;
	logic        ex_vld_q;

	// Valid bits, flush first, then stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			id_vld_q <= 1'b0;
			ex_vld_q <= 1'b0;
		end else if (i_flush) begin
			id_vld_q <= 1'b0;
			ex_vld_q <= 1'b0;
		end else if (i_stall) begin
			// ID holds, bubble into EX
			ex_vld_q <= 1'b0;
		end else begin
			id_vld_q <= 1'b1;
			ex_vld_q <= id_vld_q;
		end
	end

	// Address tags move only when fetch advances
	always_ff @(posedge clk) begin
		if (!i_stall) begin
			id_pc_q   <= i_fetch_pc;
			id_pred_q <= i_pred_next_pc;
			ex_pc_q   <= id_pc_q;
			ex_pred_q <= id_pred_q;
		end
	end

	assign o_ex_pc           = ex_pc_q;
	assign o_ex_pred_next_pc = ex_pred_q;
	assign o_ex_vld          = ex_vld_q;

endmodule

`default_nettype wire

// File: src/mispredict_check.sv
`include "bp_params.svh"

`default_nettype none

module mispredict_check (
	input  wire logic               i_ex_vld,
	input  wire bp_pkg::pc_t        i_ex_pc,
	input  wire bp_pkg::pc_t        i_ex_pred_next_pc,

	// Actual outcome of the EX instruction
	input  wire bp_pkg::ctrl_kind_t i_ex_kind,
	input  wire logic               i_ex_taken,
	input  wire bp_pkg::pc_t        i_ex_target,

	output logic                    o_mispred,
	output bp_pkg::pc_t             o_redirect_pc,

	// Training for BTB and BHT
	output logic                    o_upd_en,
	output bp_pkg::pc_t             o_upd_pc,
	output logic                    o_upd_taken,
	output bp_pkg::pc_t             o_upd_target
);

	logic        is_ctrl;
	logic        is_jump;
	logic        actual_taken;
	bp_pkg::pc_t actual_next_pc;

	assign is_jump = (i_ex_kind == `BP_KIND_JUMP);
	assign is_ctrl = i_ex_vld && ((i_ex_kind == `BP_KIND_BRANCH) || is_jump);

	// Jumps are always taken
	assign actual_taken   = is_jump || i_ex_taken;
	assign actual_next_pc = actual_taken ? i_ex_target :
		(i_ex_pc + bp_pkg::pc_t'(`BP_INSN_BYTES));

	// Covers both wrong direction and wrong target
	assign o_mispred     = is_ctrl && (actual_next_pc != i_ex_pred_next_pc);
	assign o_redirect_pc = actual_next_pc;

	assign o_upd_en     = is_ctrl;
	assign o_upd_pc     = i_ex_pc;
	assign o_upd_taken  = actual_taken;
	assign o_upd_target = i_ex_target;

endmodule

`default_nettype wire

// File: src/next_pc_select.sv
`include "bp_params.svh"

`default_nettype none

module next_pc_select (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        i_stall,

	// Prediction for the current fetch PC
	input  wire logic        i_btb_hit,
	input  wire bp_pkg::pc_t i_btb_target,
	input  wire logic        i_bht_taken,

	// Correction from EX
	input  wire logic        i_redirect,
	input  wire bp_pkg::pc_t i_redirect_pc,

	output bp_pkg::pc_t      o_fetch_pc,
	output bp_pkg::pc_t      o_pred_next_pc
);

	bp_pkg::pc_t pc_q;
	bp_pkg::pc_t pc_seq;
	bp_pkg::pc_t pc_next;
	logic        pred_taken;

	assign pc_seq = pc_q + bp_pkg::pc_t'(`BP_INSN_BYTES);

	// Direction only counts when the BTB knows a target
	assign pred_taken     = i_btb_hit && i_bht_taken;
	assign o_pred_next_pc = pred_taken ? i_btb_target : pc_seq;

	// Redirect wins over stall
	always_comb begin
		if (i_redirect) begin
			pc_next = i_redirect_pc;
		end else if (i_stall) begin
			pc_next = pc_q;
		end else begin
			pc_next = o_pred_next_pc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc_q <= `BP_RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign o_fetch_pc = pc_q;

endmodule

`default_nettype wire
